//--- Makefile
VERILATOR ?= verilator
TOP ?= tscTb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= verilog.f
VFLAGS ?= --binary --timing --assert -j 0 --timescale 1ns/100ps

SOURCES := $(shell cat $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/alu.sv
module alu (
	input logic [3:0] aluOp,
	input logic [15:0] opA, opB,
	input logic [3:0] opcode,
	output logic [15:0] result,
	output logic branchTaken
);
	import tscPkg::*;

	always_comb begin
		case (aluOp)
			aluAdd: result = opA + opB;
			aluSub: result = opA - opB;
			aluAnd: result = opA & opB;
			aluOrr: result = opA | opB;
			aluNot: result = ~opA;
			aluTcp: result = ~opA + 16'd1;
			aluShl: result = {opA[14:0], 1'b0};
			aluShr: result = {opA[15], opA[15:1]}; // Arithmetic, the sign is kept.
			aluLhi: result = {opB[7:0], 8'h00};
			default: result = '0;
		endcase
	end

	// --------------------------------------------------------------------------
	// Branch conditions
	// --------------------------------------------------------------------------
	always_comb begin
		case (opcode)
			BNE_OP: branchTaken = (opA != opB);
			BEQ_OP: branchTaken = (opA == opB);
			BGZ_OP: branchTaken = !opA[15] && (opA != '0);
			BLZ_OP: branchTaken = opA[15];
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

//--- hdl/controlUnit.sv
module controlUnit (
	input tscPkg::instrWord_u instr,
	output logic regWrite, aluSrcB, memRead, memWrite, memtoReg,
	output logic isBranch, isWwd, isHalt, isLink,
	output logic rType, iType, jType,
	output logic [3:0] aluOp,
	output logic [1:0] pcSrc
);
	import tscPkg::*;

	always_comb begin
		regWrite = 1'b0; // Anything not matched below is a no-operation.
		aluSrcB = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memtoReg = 1'b0;
		isBranch = 1'b0;
		isWwd = 1'b0;
		isHalt = 1'b0;
		isLink = 1'b0;
		rType = 1'b0;
		iType = 1'b0;
		jType = 1'b0;
		aluOp = aluAdd;
		pcSrc = pcNext;

		case (instr.r.opcode)
			ALU_OP: begin
				rType = 1'b1;
				case (instr.r.func)
					INST_FUNC_SUB: aluOp = aluSub;
					INST_FUNC_AND: aluOp = aluAnd;
					INST_FUNC_ORR: aluOp = aluOrr;
					INST_FUNC_NOT: aluOp = aluNot;
					INST_FUNC_TCP: aluOp = aluTcp;
					INST_FUNC_SHL: aluOp = aluShl;
					INST_FUNC_SHR: aluOp = aluShr;
					default: aluOp = aluAdd;
				endcase
				case (instr.r.func)
					INST_FUNC_ADD, INST_FUNC_SUB, INST_FUNC_AND, INST_FUNC_ORR,
					INST_FUNC_NOT, INST_FUNC_TCP, INST_FUNC_SHL, INST_FUNC_SHR:
						regWrite = 1'b1;
					INST_FUNC_JPR: pcSrc = pcReg;
					INST_FUNC_JRL: begin
						pcSrc = pcReg;
						regWrite = 1'b1;
						isLink = 1'b1; // Register 2 takes the return address.
					end
					INST_FUNC_WWD: isWwd = 1'b1;
					INST_FUNC_HLT: isHalt = 1'b1;
					default: rType = 1'b0;
				endcase
			end
			ADI_OP, ORI_OP, LHI_OP: begin
				iType = 1'b1;
				regWrite = 1'b1;
				aluSrcB = 1'b1;
				if (instr.i.opcode == ORI_OP) aluOp = aluOrr;
				else if (instr.i.opcode == LHI_OP) aluOp = aluLhi;
			end
			LWD_OP, SWD_OP: begin
				iType = 1'b1;
				aluSrcB = 1'b1; // Address is rs plus the offset.
				memRead = (instr.i.opcode == LWD_OP);
				memtoReg = (instr.i.opcode == LWD_OP);
				regWrite = (instr.i.opcode == LWD_OP);
				memWrite = (instr.i.opcode == SWD_OP);
			end
			BNE_OP, BEQ_OP, BGZ_OP, BLZ_OP: begin
				iType = 1'b1;
				isBranch = 1'b1; // Operand B stays on rt for the compare.
			end
			JMP_OP, JAL_OP: begin
				jType = 1'b1;
				pcSrc = pcJump;
				regWrite = (instr.j.opcode == JAL_OP);
				isLink = (instr.j.opcode == JAL_OP);
			end
			default: ;
		endcase
	end

endmodule

//--- hdl/cycleSequencer.sv
module cycleSequencer (
	input logic clk, rstN,
	input logic memRead, memWrite, isHalt,
	output logic instrRead, irLoad, dataRead, dataWrite,
	output logic wbEnable, pcUpdate, halted
);
	import tscPkg::*;

	seqState_e state, nextState;
	logic running; // Holds the first fetch back until reset has been released.

	always_comb begin
		nextState = state;
		case (state)
			FETCH: nextState = running ? DECODE : FETCH;
			DECODE: nextState = EXEC;
			EXEC: nextState = (memRead || memWrite) ? MEM : WB;
			MEM: nextState = WB;
			WB: nextState = isHalt ? HALT : FETCH;
			default: nextState = HALT; // HALT is left only through reset.
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= FETCH;
			running <= 1'b0;
		end else begin
			state <= nextState;
			running <= 1'b1;
		end
	end

	// --------------------------------------------------------------------------
	// Strobes and write enables
	// --------------------------------------------------------------------------
	assign instrRead = (state == FETCH) && running;
	assign irLoad = (state == DECODE); // Instruction data arrives in this cycle.
	assign dataRead = (state == MEM) && memRead;
	assign dataWrite = (state == MEM) && memWrite;
	assign wbEnable = (state == WB);
	assign pcUpdate = (state == WB) && !isHalt; // The PC stays on a halt.
	assign halted = (state == HALT);

endmodule

//--- hdl/pcCounter.sv
module pcCounter (
	input logic clk, rstN, pcUpdate, branchTaken,
	input logic [1:0] pcSrc,
	input logic [7:0] immediate,
	input logic [11:0] target,
	input logic [15:0] regValue,
	output logic [15:0] pc, pcPlusOne
);
	import tscPkg::*;

	logic [15:0] branchTarget, pcLoad;

	assign pcPlusOne = pc + 16'd1;
	assign branchTarget = pcPlusOne + {{8{immediate[7]}}, immediate};

	always_comb begin
		case (pcSrc)
			pcNext: pcLoad = branchTaken ? branchTarget : pcPlusOne;
			pcJump: pcLoad = {pc[15:12], target}; // Stays in the current 4K page.
			pcReg: pcLoad = regValue;
			default: pcLoad = pcPlusOne;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (pcUpdate) begin
			pc <= pcLoad;
		end
	end

endmodule

//--- hdl/regFile.sv
module regFile (
	input logic clk, rstN, writeEnable,
	input logic [1:0] readAddr1, readAddr2, writeAddr,
	input logic [15:0] writeData,
	output logic [15:0] readData1, readData2
);

	logic [15:0] regs [4];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < 4; k++) begin
				regs[k] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

	// No bypass, the write lands on the edge that ends the instruction.
	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

endmodule

//--- hdl/tscCore.sv
module tscCore (
	input logic clk, rstN,
	output logic [15:0] instrAddr,
	output logic instrRead,
	input logic [15:0] instrData,
	output logic [15:0] dataAddr, dataWdata,
	output logic dataRead, dataWrite,
	input logic [15:0] dataRdata,
	output logic [15:0] outputPort,
	output logic outputValid, halted
);
	import tscPkg::*;

	instrWord_u ir;
	logic regWrite, aluSrcB, memRead, memWrite, memtoReg;
	logic isBranch, isWwd, isHalt, isLink, rType, iType, jType;
	logic [3:0] aluOp;
	logic [1:0] pcSrc, destAddr;
	logic irLoad, wbEnable, pcUpdate, aluTaken;
	logic [wordSize-1:0] pc, pcPlusOne, regA, regB, immExt, opB, aluResult, writeData;

	always_ff @(posedge clk) begin
		if (irLoad) begin
			ir <= instrData;
		end
	end

	// --------------------------------------------------------------------------
	// Operand, writeback and destination selection
	// --------------------------------------------------------------------------
	assign immExt = (ir.i.opcode == ORI_OP) ? {8'h00, ir.i.imm} : {{8{ir.i.imm[7]}}, ir.i.imm};
	assign opB = aluSrcB ? immExt : regB;

	// Load data is valid only in WB, which is the cycle the register file writes.
	assign writeData = isLink ? pcPlusOne : (memtoReg ? dataRdata : aluResult);

	always_comb begin
		case (1'b1)
			jType: destAddr = 2'd2; // JAL.
			rType: destAddr = isLink ? 2'd2 : ir.r.rd;
			iType: destAddr = ir.i.rt;
			default: destAddr = 2'd0;
		endcase
	end

	assign instrAddr = pc;
	assign dataAddr = aluResult;
	assign dataWdata = regB;
	assign outputPort = regA;
	assign outputValid = wbEnable && isWwd;

	controlUnit uControl (
		.instr(ir), .regWrite(regWrite), .aluSrcB(aluSrcB), .memRead(memRead),
		.memWrite(memWrite), .memtoReg(memtoReg), .isBranch(isBranch), .isWwd(isWwd),
		.isHalt(isHalt), .isLink(isLink), .rType(rType), .iType(iType), .jType(jType),
		.aluOp(aluOp), .pcSrc(pcSrc)
	);

	cycleSequencer uSequencer (
		.clk(clk), .rstN(rstN), .memRead(memRead), .memWrite(memWrite), .isHalt(isHalt),
		.instrRead(instrRead), .irLoad(irLoad), .dataRead(dataRead), .dataWrite(dataWrite),
		.wbEnable(wbEnable), .pcUpdate(pcUpdate), .halted(halted)
	);

	pcCounter uPc (
		.clk(clk), .rstN(rstN), .pcUpdate(pcUpdate), .branchTaken(isBranch && aluTaken),
		.pcSrc(pcSrc), .immediate(ir.i.imm), .target(ir.j.target), .regValue(regA),
		.pc(pc), .pcPlusOne(pcPlusOne)
	);

	regFile uRegs (
		.clk(clk), .rstN(rstN), .writeEnable(wbEnable && regWrite),
		.readAddr1(ir.r.rs), .readAddr2(ir.r.rt), .writeAddr(destAddr),
		.writeData(writeData), .readData1(regA), .readData2(regB)
	);

	alu uAlu (
		.aluOp(aluOp), .opA(regA), .opB(opB), .opcode(ir.i.opcode),
		.result(aluResult), .branchTaken(aluTaken)
	);

endmodule

//--- hdl/tscPkg.sv
package tscPkg;

	localparam int wordSize = 16;

	// --------------------------------------------------------------------------
	// Opcodes
	// --------------------------------------------------------------------------
	localparam logic [3:0] BNE_OP = 4'd0;
	localparam logic [3:0] BEQ_OP = 4'd1;
	localparam logic [3:0] BGZ_OP = 4'd2;
	localparam logic [3:0] BLZ_OP = 4'd3;
	localparam logic [3:0] ADI_OP = 4'd4;
	localparam logic [3:0] ORI_OP = 4'd5;
	localparam logic [3:0] LHI_OP = 4'd6;
	localparam logic [3:0] LWD_OP = 4'd7;
	localparam logic [3:0] SWD_OP = 4'd8;
	localparam logic [3:0] JMP_OP = 4'd9;
	localparam logic [3:0] JAL_OP = 4'd10;
	localparam logic [3:0] ALU_OP = 4'd15; // R-format, the function field selects.

	localparam logic [5:0] INST_FUNC_ADD = 6'd0;
	localparam logic [5:0] INST_FUNC_SUB = 6'd1;
	localparam logic [5:0] INST_FUNC_AND = 6'd2;
	localparam logic [5:0] INST_FUNC_ORR = 6'd3;
	localparam logic [5:0] INST_FUNC_NOT = 6'd4;
	localparam logic [5:0] INST_FUNC_TCP = 6'd5;
	localparam logic [5:0] INST_FUNC_SHL = 6'd6;
	localparam logic [5:0] INST_FUNC_SHR = 6'd7;
	localparam logic [5:0] INST_FUNC_JPR = 6'd25;
	localparam logic [5:0] INST_FUNC_JRL = 6'd26;
	localparam logic [5:0] INST_FUNC_WWD = 6'd28;
	localparam logic [5:0] INST_FUNC_HLT = 6'd29;

	// --------------------------------------------------------------------------
	// Datapath selectors
	// --------------------------------------------------------------------------
	localparam logic [3:0] aluAdd = 4'd0;
	localparam logic [3:0] aluSub = 4'd1;
	localparam logic [3:0] aluAnd = 4'd2;
	localparam logic [3:0] aluOrr = 4'd3;
	localparam logic [3:0] aluNot = 4'd4;
	localparam logic [3:0] aluTcp = 4'd5;
	localparam logic [3:0] aluShl = 4'd6;
	localparam logic [3:0] aluShr = 4'd7;
	localparam logic [3:0] aluLhi = 4'd8;

	localparam logic [1:0] pcNext = 2'd0; // Increment, or branch when taken.
	localparam logic [1:0] pcJump = 2'd1;
	localparam logic [1:0] pcReg = 2'd2;

	typedef struct packed {
		logic [3:0] opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [5:0] func;
	} rFields_s;

	typedef struct packed {
		logic [3:0] opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [7:0] imm;
	} iFields_s;

	typedef struct packed {
		logic [3:0] opcode;
		logic [11:0] target;
	} jFields_s;

	typedef union packed {
		rFields_s r;
		iFields_s i;
		jFields_s j;
	} instrWord_u;

	typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, WB, HALT} seqState_e;

endpackage

//--- sim/tscChecker.sv
module tscChecker (
	input logic clk, rstN,
	input logic instrRead, dataRead, dataWrite, outputValid, halted,
	input logic [15:0] instrAddr, dataAddr, dataWdata, outputPort,
	input logic [15:0] progMem [256],
	input logic [15:0] initMem [256],
	input int testIdx,
	output int errors
);
	timeunit 1ns;
	timeprecision 100ps;
	import tscPkg::*;

	logic [15:0] shadowRegs [4];
	logic [15:0] shadowMem [256];
	logic [15:0] shadowPc;
	logic [15:0] expOutputs [$];
	logic [15:0] expFetches [$];
	logic [31:0] expStores [$];
	int expInstrs, fetchCount;
	logic active, haltSeen;

	function automatic string testName(input int idx);
		case (idx)
			0: return "aluOps";
			1: return "immediates";
			2: return "loadStore";
			3: return "branches";
			4: return "jumps";
			default: return "halt";
		endcase
	endfunction

	// --------------------------------------------------------------------------
	// ISA model that runs one instruction per call and returns 1 on HLT
	// --------------------------------------------------------------------------
	function automatic logic executeInstr(input instrWord_u w);
		logic [15:0] a, b, sImm, addr, pcNow;
		logic take;
		a = shadowRegs[w.r.rs];
		b = shadowRegs[w.r.rt];
		sImm = {{8{w.i.imm[7]}}, w.i.imm};
		pcNow = shadowPc;
		expFetches.push_back(pcNow);
		shadowPc = shadowPc + 16'd1; // From here on the PC holds the link value.
		take = 1'b0;
		case (w.r.opcode)
			ALU_OP: begin
				case (w.r.func)
					INST_FUNC_ADD: shadowRegs[w.r.rd] = a + b;
					INST_FUNC_SUB: shadowRegs[w.r.rd] = a - b;
					INST_FUNC_AND: shadowRegs[w.r.rd] = a & b;
					INST_FUNC_ORR: shadowRegs[w.r.rd] = a | b;
					INST_FUNC_NOT: shadowRegs[w.r.rd] = ~a;
					INST_FUNC_TCP: shadowRegs[w.r.rd] = 16'd0 - a;
					INST_FUNC_SHL: shadowRegs[w.r.rd] = a << 1;
					INST_FUNC_SHR: shadowRegs[w.r.rd] = $signed(a) >>> 1;
					INST_FUNC_JPR: shadowPc = a;
					INST_FUNC_JRL: begin
						shadowRegs[2] = shadowPc;
						shadowPc = a;
					end
					INST_FUNC_WWD: expOutputs.push_back(a);
					INST_FUNC_HLT: return 1'b1;
					default: ;
				endcase
			end
			ADI_OP: shadowRegs[w.i.rt] = a + sImm;
			ORI_OP: shadowRegs[w.i.rt] = a | {8'h00, w.i.imm};
			LHI_OP: shadowRegs[w.i.rt] = {w.i.imm, 8'h00};
			LWD_OP: begin
				addr = a + sImm;
				shadowRegs[w.i.rt] = shadowMem[addr[7:0]];
			end
			SWD_OP: begin
				addr = a + sImm;
				shadowMem[addr[7:0]] = b;
				expStores.push_back({addr, b});
			end
			BNE_OP: take = (a != b);
			BEQ_OP: take = (a == b);
			BGZ_OP: take = ($signed(a) > 16'sd0);
			BLZ_OP: take = ($signed(a) < 16'sd0);
			JMP_OP: shadowPc = {pcNow[15:12], w.j.target};
			JAL_OP: begin
				shadowRegs[2] = shadowPc;
				shadowPc = {pcNow[15:12], w.j.target};
			end
			default: ;
		endcase
		if (take) shadowPc = shadowPc + sImm;
		return 1'b0;
	endfunction

	task automatic prepareModel();
		logic done;
		shadowRegs = '{default: 16'h0000};
		shadowMem = initMem;
		shadowPc = '0;
		expOutputs.delete();
		expFetches.delete();
		expStores.delete();
		fetchCount = 0;
		haltSeen = 1'b0;
		expInstrs = 0;
		done = 1'b0;
		while (!done && expInstrs < 1000) begin
			done = executeInstr(progMem[shadowPc[7:0]]);
			expInstrs++;
		end
	endtask

	task automatic compareCycle();
		logic [31:0] st;
		logic [15:0] ow;
		logic [15:0] fa;
		if (haltSeen && (instrRead || dataRead || dataWrite || outputValid)) begin
			$display("Error in %s: a strobe or output appeared after the halt", testName(testIdx));
			errors++;
		end
		if (instrRead) begin
			fetchCount++;
			if (expFetches.size() == 0) begin
				$display("Error in %s: fetch from %h beyond the end of the model's program",
					testName(testIdx), instrAddr);
				errors++;
			end else begin
				fa = expFetches.pop_front();
				if (instrAddr !== fa) begin
					$display("FAIL %s instrAddr: expected %h, actual %h",
						testName(testIdx), fa, instrAddr);
					errors++;
				end
			end
		end
		if (outputValid) begin
			if (expOutputs.size() == 0) begin
				$display("Error in %s: output %h was not expected", testName(testIdx), outputPort);
				errors++;
			end else begin
				ow = expOutputs.pop_front();
				if (outputPort !== ow) begin
					$display("FAIL %s outputPort: expected %h, actual %h",
						testName(testIdx), ow, outputPort);
					errors++;
				end
			end
		end
		if (dataWrite) begin
			if (expStores.size() == 0) begin
				$display("Error in %s: store to %h that the model did not expect",
					testName(testIdx), dataAddr);
				errors++;
			end else begin
				st = expStores.pop_front();
				if ({dataAddr, dataWdata} !== st) begin
					$display("FAIL %s store addr/data: expected %h/%h, actual %h/%h",
						testName(testIdx), st[31:16], st[15:0], dataAddr, dataWdata);
					errors++;
				end
			end
		end
		if (halted && !haltSeen) begin
			haltSeen = 1'b1;
			if (fetchCount != expInstrs) begin
				$display("Error in %s: halt came too %s, after %0d instructions instead of %0d",
					testName(testIdx), (fetchCount < expInstrs) ? "early" : "late",
					fetchCount, expInstrs);
				errors++;
			end
			if (expOutputs.size() != 0 || expStores.size() != 0) begin
				$display("Error in %s: halted with %0d outputs and %0d stores still missing",
					testName(testIdx), expOutputs.size(), expStores.size());
				errors++;
			end
		end
	endtask

	// The model runs once per test, on the first falling edge after reset.
	always @(negedge clk) begin
		if (!rstN) begin
			active = 1'b0;
		end else if (!active) begin
			prepareModel();
			active = 1'b1;
		end else begin
			compareCycle();
		end
	end

endmodule

//--- sim/tscCore_properties.sv
module tscCore_properties (
	input logic clk, rstN,
	input tscPkg::seqState_e state,
	input logic instrRead, dataRead, dataWrite, halted
);
	timeunit 1ns;
	timeprecision 100ps;
	import tscPkg::*;

	// --------------------------------------------------------------------------
	// Memory strobes
	// --------------------------------------------------------------------------
	instrPulse: assert property (@(posedge clk) disable iff (!rstN) instrRead |=> !instrRead)
		else $error("instrRead stayed high for more than one cycle");
	readPulse: assert property (@(posedge clk) disable iff (!rstN) dataRead |=> !dataRead)
		else $error("dataRead stayed high for more than one cycle");
	writePulse: assert property (@(posedge clk) disable iff (!rstN) dataWrite |=> !dataWrite)
		else $error("dataWrite stayed high for more than one cycle");
	readWriteApart: assert property (@(posedge clk) disable iff (!rstN) !(dataRead && dataWrite))
		else $error("dataRead and dataWrite were high together");

	// Halt is terminal until the next reset.
	haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
		else $error("halted dropped without a reset");
	haltQuiet: assert property (@(posedge clk) disable iff (!rstN)
		(state == HALT) |-> !(instrRead || dataRead || dataWrite))
		else $error("a memory strobe was high in the HALT state");

endmodule

bind cycleSequencer tscCore_properties uProps (
	.clk(clk), .rstN(rstN), .state(state), .instrRead(instrRead),
	.dataRead(dataRead), .dataWrite(dataWrite), .halted(halted)
);

//--- sim/tscTb.sv
module tscTb;
	timeunit 1ns;
	timeprecision 100ps;
	import tscPkg::*;

	logic clk, rstN;
	logic [15:0] instrAddr, instrData, dataAddr, dataWdata, dataRdata, outputPort;
	logic instrRead, dataRead, dataWrite, outputValid, halted;
	logic [15:0] imem [256];
	logic [15:0] seedMem [256]; // Data memory contents at reset release.
	logic [15:0] dmem [256];
	logic [31:0] rngState;
	int progLen, watchLimit, testIdx, errors;
	logic testRunning;

	tscCore u_dut (.*);

	tscChecker uChecker (
		.clk(clk), .rstN(rstN), .instrRead(instrRead), .dataRead(dataRead),
		.dataWrite(dataWrite), .outputValid(outputValid), .halted(halted),
		.instrAddr(instrAddr), .dataAddr(dataAddr), .dataWdata(dataWdata),
		.outputPort(outputPort), .progMem(imem), .initMem(seedMem), .testIdx(testIdx),
		.errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [15:0] randomWord();
		rngState = xorshift(rngState);
		return rngState[15:0];
	endfunction

	function automatic logic [15:0] rWord(input logic [5:0] func, input logic [1:0] rs, rt, rd);
		return {ALU_OP, rs, rt, rd, func};
	endfunction

	function automatic logic [15:0] iWord(input logic [3:0] op, input logic [1:0] rs, rt,
		input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] jWord(input logic [3:0] op, input logic [11:0] target);
		return {op, target};
	endfunction

	task automatic emit(input logic [15:0] word);
		imem[8'(progLen)] = word;
		progLen++;
	endtask

	task automatic setReg(input logic [1:0] r, input logic [15:0] value);
		emit(iWord(LHI_OP, 2'd0, r, value[15:8]));
		emit(iWord(ORI_OP, r, r, value[7:0]));
	endtask

	task automatic showReg(input logic [1:0] r);
		emit(rWord(INST_FUNC_WWD, r, 2'd0, 2'd0));
	endtask

	task automatic emitHalt();
		emit(rWord(INST_FUNC_HLT, 2'd0, 2'd0, 2'd0));
	endtask

	// Fall-through writes mark, the taken path writes mark + 1.
	task automatic branchBlock(input logic [3:0] op, input logic [1:0] rs, rt,
		input logic [7:0] mark);
		int after;
		after = progLen + 6;
		emit(iWord(op, rs, rt, 8'd3));
		emit(iWord(LHI_OP, 2'd0, 2'd3, mark));
		showReg(2'd3);
		emit(jWord(JMP_OP, 12'(after)));
		emit(iWord(LHI_OP, 2'd0, 2'd3, mark + 8'd1));
		showReg(2'd3);
	endtask

	// --------------------------------------------------------------------------
	// Programs
	// --------------------------------------------------------------------------
	task automatic buildAluOps();
		for (int pass = 0; pass < 2; pass++) begin
			setReg(2'd0, randomWord());
			setReg(2'd1, randomWord());
			for (int f = 0; f < 8; f++) begin
				emit(rWord(6'(f), 2'd0, 2'd1, 2'd3));
				showReg(2'd3);
			end
		end
		emitHalt();
	endtask

	task automatic buildImmediates();
		logic [7:0] imms [4];
		imms = '{8'hFF, 8'h80, 8'h7F, 8'hC7};
		setReg(2'd0, randomWord());
		foreach (imms[k]) begin
			emit(iWord(ADI_OP, 2'd0, 2'd1, imms[k]));
			showReg(2'd1);
			emit(iWord(ORI_OP, 2'd0, 2'd2, imms[k]));
			showReg(2'd2);
			emit(iWord(LHI_OP, 2'd0, 2'd3, imms[k]));
			showReg(2'd3);
		end
		emitHalt();
	endtask

	task automatic buildLoadStore();
		logic [7:0] offs [4];
		offs = '{8'h00, 8'h05, 8'hFD, 8'h7F};
		setReg(2'd0, 16'h0040);
		setReg(2'd1, randomWord());
		foreach (offs[k]) begin
			emit(iWord(SWD_OP, 2'd0, 2'd1, offs[k]));
			emit(iWord(ADI_OP, 2'd1, 2'd1, 8'd1));
		end
		offs = '{8'h05, 8'hFD, 8'h10, 8'h80}; // The last two read seeded words.
		foreach (offs[k]) begin
			emit(iWord(LWD_OP, 2'd0, 2'd2, offs[k]));
			showReg(2'd2);
		end
		emitHalt();
	endtask

	task automatic buildBranches();
		logic [15:0] r;
		r = randomWord();
		setReg(2'd0, {1'b0, r[14:1], 1'b1}); // Positive and never zero.
		emit(iWord(ADI_OP, 2'd0, 2'd1, 8'd0));
		r = randomWord();
		setReg(2'd2, {1'b1, r[14:0]}); // Negative.
		branchBlock(BNE_OP, 2'd0, 2'd1, 8'h10);
		branchBlock(BNE_OP, 2'd0, 2'd2, 8'h20);
		branchBlock(BEQ_OP, 2'd0, 2'd1, 8'h30);
		branchBlock(BEQ_OP, 2'd0, 2'd2, 8'h40);
		branchBlock(BGZ_OP, 2'd0, 2'd0, 8'h50);
		branchBlock(BGZ_OP, 2'd2, 2'd0, 8'h60);
		branchBlock(BLZ_OP, 2'd2, 2'd0, 8'h70);
		branchBlock(BLZ_OP, 2'd0, 2'd0, 8'h80);
		emitHalt();
	endtask

	task automatic buildJumps();
		emit(iWord(LHI_OP, 2'd0, 2'd3, 8'h11));
		emit(jWord(JMP_OP, 12'd3));
		showReg(2'd3); // Skipped by the jump.
		emit(iWord(LHI_OP, 2'd0, 2'd3, 8'h22));
		showReg(2'd3);
		emit(jWord(JAL_OP, 12'd14));
		emit(iWord(LHI_OP, 2'd0, 2'd3, 8'h33));
		showReg(2'd3);
		setReg(2'd1, 16'd16);
		emit(rWord(INST_FUNC_JRL, 2'd1, 2'd0, 2'd0));
		emit(iWord(LHI_OP, 2'd0, 2'd3, 8'h44));
		showReg(2'd3);
		emitHalt();
		showReg(2'd2); // Address 14 shows the JAL link.
		emit(rWord(INST_FUNC_JPR, 2'd2, 2'd0, 2'd0));
		showReg(2'd2); // Address 16 shows the JRL link.
		emit(rWord(INST_FUNC_JPR, 2'd2, 2'd0, 2'd0));
	endtask

	task automatic buildHalt();
		setReg(2'd0, randomWord());
		showReg(2'd0);
		emitHalt();
		showReg(2'd0);
		showReg(2'd0);
	endtask

	task automatic runTest(input int idx);
		@(posedge clk);
		#0.5;
		rstN = 1'b0;
		testIdx = idx;
		progLen = 0;
		for (int a = 0; a < 256; a++) begin
			imem[8'(a)] = rWord(INST_FUNC_HLT, 2'd0, 2'd0, 2'd0);
			seedMem[8'(a)] = randomWord() ^ 16'(a);
		end
		case (idx)
			0: buildAluOps();
			1: buildImmediates();
			2: buildLoadStore();
			3: buildBranches();
			4: buildJumps();
			default: buildHalt();
		endcase
		watchLimit = progLen * 5 + 50;
		repeat (5) @(posedge clk);
		#0.5;
		rstN = 1'b1;
		testRunning = 1'b1;
		while (!halted) begin
			@(posedge clk);
			#0.5;
		end
		testRunning = 1'b0;
		repeat ((idx == 5) ? 50 : 5) @(posedge clk);
	endtask

	// Both memories answer one cycle after the strobe.
	initial begin
		logic iReq, dRd, dWr;
		logic [15:0] iAddr, dAddr, dWdata;
		instrData = '0;
		dataRdata = '0;
		forever begin
			@(negedge clk);
			if (!rstN) dmem = seedMem;
			iReq = instrRead;
			iAddr = instrAddr;
			dRd = dataRead;
			dWr = dataWrite;
			dAddr = dataAddr;
			dWdata = dataWdata;
			@(posedge clk);
			#0.5;
			if (iReq) instrData = imem[iAddr[7:0]];
			if (dRd) dataRdata = dmem[dAddr[7:0]];
			if (dWr) dmem[dAddr[7:0]] = dWdata;
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= watchLimit) begin
			@(posedge clk);
			cycles = testRunning ? cycles + 1 : 0;
		end
		$display("Timeout: test %0d did not halt within %0d cycles", testIdx, watchLimit);
		$display("Closing report: %0d errors plus the timeout", errors);
		$display("tests failed");
		$finish;
	end

	initial begin
		rngState = 32'h7c0c_2564;
		rstN = 1'b0;
		testRunning = 1'b0;
		watchLimit = 0;
		testIdx = 0;
		for (int t = 0; t < 6; t++) begin
			runTest(t);
		end
		$display("Closing report: %0d errors", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
hdl/tscPkg.sv
hdl/alu.sv
hdl/regFile.sv
hdl/pcCounter.sv
hdl/cycleSequencer.sv
hdl/controlUnit.sv
hdl/tscCore.sv
sim/tscCore_properties.sv
sim/tscChecker.sv
sim/tscTb.sv
